/* Bender.yml */
package:
  name: c16_core

sources:
  - verilog/c16_pkg.sv
  - verilog/instr_queue.sv
  - verilog/slot_decode.sv
  - verilog/issue_ctrl.sv
  - verilog/reg_file.sv
  - verilog/exec_lane.sv
  - verilog/c16_core.sv
  - target: test
    files:
      - verif/c16_asserts.sv
      - verif/c16_tb.sv

/* verif/c16_asserts.sv */
////////////////////////////////////////////////////////////
// Bound to c16_core; fetch handshake and writeback lanes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module c16_asserts
   import c16_pkg::*;
(
   input logic        clk,
   input logic        reset,
   input fetch_word_t fetch_word,
   input logic        fetch_valid,
   input logic        fetch_ready,
   input issue_slot_t slot_first,
   input writeback_t  wb_first,
   input writeback_t  wb_second
);

   int fail_count = 0;

   // Lane second only issues together with lane first,
   // which may hold an older instruction that decoded as a NOP
   second_needs_first: assert property (
      @(posedge clk) disable iff (reset)
         wb_second.en |-> (wb_first.en || $past(slot_first.op) == ALU_NOP)
   ) else begin
      fail_count++;
      $error("wb_second.en high while lane first dropped a real instruction");
   end

   fetch_word_held: assert property (
      @(posedge clk) disable iff (reset)
         (fetch_valid && !fetch_ready) |=> $stable(fetch_word)
   ) else begin
      fail_count++;
      $error("fetch_word changed while waiting for fetch_ready");
   end

   quiet_after_reset: assert property (
      @(posedge clk) $fell(reset) |-> (!wb_first.en && !wb_second.en)
   ) else begin
      fail_count++;
      $error("writeback enabled in the first cycle after reset");
   end

endmodule

bind c16_core c16_asserts c16_asserts_inst (
   .clk(clk), .reset(reset),
   .fetch_word(fetch_word), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
   .slot_first(slot_first),
   .wb_first(wb_first), .wb_second(wb_second)
);

/* verif/c16_tb.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for c16_core, in-order compare
// Expected writebacks come from a model register file
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module c16_tb
   import c16_pkg::*;
();

   localparam int WAIT_LIMIT = 50;
   localparam int DRAIN_LIMIT = 200;

   logic        clk;
   logic        reset;
   fetch_word_t fetch_word;
   logic        fetch_valid;
   logic        fetch_ready;
   writeback_t  wb_first;
   writeback_t  wb_second;

   integer     seed;
   word_t      model_regs [NUM_REGS];
   writeback_t exp_q [$];
   int         exp_tag [$];
   int         same_tags [$];
   int         later_tags [$];
   int         wb_cycle [512];
   int         n_inst = 0;
   int         cycle = 0;
   int         errors = 0;
   int         timeouts = 0;
   logic       aborted = 1'b0;

   c16_core c16_core_inst (
      .clk(clk), .reset(reset),
      .fetch_word(fetch_word), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
      .wb_first(wb_first), .wb_second(wb_second)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Reference model and stimulus helpers
   ////////////////////////////////////////////////////////////

   // Runs one instruction in program order; r7 is never written so reads zero
   function automatic writeback_t ref_exec(word_t inst);
      writeback_t wb;
      opcode_t    opc;
      word_t      a;
      word_t      b;
      opc = inst[15:11];
      a = model_regs[inst[7:5]];
      b = (opc == OPC_ADD_REG || opc == OPC_SUB_REG) ? model_regs[inst[2:0]]
                                                     : {{11{inst[4]}}, inst[4:0]};
      wb.en = (opc < 5'd4);
      wb.addr = inst[10:8];
      wb.value = (opc == OPC_ADD_IMM || opc == OPC_ADD_REG) ? a + b : a - b;
      if (wb.en && wb.addr != NO_WRITE_REG) begin
         model_regs[wb.addr] = wb.value;
      end
      return wb;
   endfunction

   function automatic word_t make_inst(opcode_t opc, reg_addr_t rd, reg_addr_t rs1,
                                       logic [4:0] low);
      return {opc, rd, rs1, low};
   endfunction

   // A fifth of the picks is an unknown opcode
   function automatic word_t random_inst();
      int      pick;
      opcode_t opc;
      pick = $unsigned($random(seed)) % 5;
      opc = (pick == 4) ? 5'd21 : opcode_t'(pick);
      return {opc, 3'($random(seed)), 3'($random(seed)), 5'($random(seed))};
   endfunction

   task automatic expect_inst(input word_t inst);
      writeback_t wb;
      wb = ref_exec(inst);
      if (wb.en) begin
         exp_q.push_back(wb);
         exp_tag.push_back(n_inst);
      end
      n_inst++;
   endtask

   // Called 2 ns after an edge; leaves valid high after the transfer
   task automatic send_word(input word_t lo, input word_t hi, output int tag);
      int waited;
      tag = n_inst;
      waited = 0;
      fetch_word = {hi, lo};
      fetch_valid = 1'b1;
      while (!fetch_ready && !aborted) begin
         @(posedge clk);
         #2;
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("Timeout: fetch_ready stayed low for %0d cycles", waited);
            timeouts++;
            aborted = 1'b1;
         end
      end
      if (!aborted) begin
         expect_inst(lo);
         expect_inst(hi);
         @(posedge clk);
         #2;
      end
   endtask

   task automatic idle(input int n);
      fetch_valid = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   task automatic check_writeback(input writeback_t got, input writeback_t exp);
      if (got !== exp) begin
         errors++;
         $display("error %0t: writeback r%0d=%h en=%b, expected r%0d=%h", $time,
                  got.addr, got.value, got.en, exp.addr, exp.value);
      end
   endtask

   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("error %0t: fetch_ready=%b, expected %b", $time, got, exp);
      end
   endtask

   task automatic check_cycle_order(input int tag, input logic same);
      int a;
      int b;
      a = wb_cycle[tag];
      b = wb_cycle[tag + 1];
      if ((same && a != b) || (!same && b <= a)) begin
         errors++;
         $display("error %0t: instructions %0d and %0d written back in cycles %0d and %0d",
                  $time, tag, tag + 1, a, b);
      end
   endtask

   task automatic take_writeback(input writeback_t got);
      if (exp_q.size() == 0) begin
         errors++;
         $display("Unexpected writeback to r%0d while nothing was pending", got.addr);
      end else begin
         check_writeback(got, exp_q.pop_front());
         wb_cycle[exp_tag.pop_front()] = cycle;
      end
   endtask

   // Compare process, samples the stable writebacks at the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         cycle++;
         if (wb_first.en) begin
            take_writeback(wb_first);
         end
         if (wb_second.en) begin
            take_writeback(wb_second);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int tag;
      int waited;
      int assert_fails;
      seed = 23;
      reset = 1'b1;
      fetch_valid = 1'b0;
      fetch_word = '0;
      for (int r = 0; r < NUM_REGS; r++) begin
         model_regs[r] = '0;
      end
      for (int i = 0; i < 512; i++) begin
         wb_cycle[i] = -1;
      end
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;

      // Empty queue after reset accepts a word
      check_ready(fetch_ready, 1'b1);

      // Independent pairs straight from reset, no gaps
      for (int k = 0; k < 6; k++) begin
         send_word(make_inst(OPC_ADD_IMM, 3'd1, 3'd2, 5'(k + 1)),
                   make_inst(OPC_SUB_IMM, 3'd2, 3'd2, 5'h1d), tag);
         same_tags.push_back(tag);
      end

      // Random program with random gaps in fetch_valid
      for (int k = 0; k < 50; k++) begin
         if ($unsigned($random(seed)) % 4 == 0) begin
            idle(1 + $unsigned($random(seed)) % 2);
         end
         send_word(random_inst(), random_inst(), tag);
      end
      idle(6);

      // Queue has drained during the gap
      check_ready(fetch_ready, 1'b1);

      // Same register from both lanes, then r7 and dependent pairs
      send_word(make_inst(OPC_ADD_IMM, 3'd5, 3'd0, 5'd3),
                make_inst(OPC_ADD_IMM, 3'd5, 3'd0, 5'd7), tag);
      same_tags.push_back(tag);
      send_word(make_inst(OPC_ADD_IMM, 3'd7, 3'd0, 5'd9),
                make_inst(OPC_ADD_IMM, 3'd4, 3'd7, 5'd1), tag);
      later_tags.push_back(tag);
      send_word(make_inst(OPC_ADD_IMM, 3'd6, 3'd5, 5'd0),
                make_inst(OPC_SUB_REG, 3'd0, 3'd7, {2'b00, 3'd6}), tag);
      later_tags.push_back(tag);
      send_word(make_inst(OPC_ADD_IMM, 3'd2, 3'd1, 5'd5),
                make_inst(OPC_ADD_REG, 3'd3, 3'd0, {2'b00, 3'd2}), tag);
      later_tags.push_back(tag);
      send_word(make_inst(OPC_SUB_IMM, 3'd1, 3'd3, 5'd2),
                make_inst(OPC_SUB_REG, 3'd4, 3'd1, {2'b00, 3'd6}), tag);
      later_tags.push_back(tag);
      send_word(make_inst(5'd30, 3'd2, 3'd2, 5'd1),
                make_inst(OPC_ADD_IMM, 3'd6, 3'd7, 5'h1f), tag);
      fetch_valid = 1'b0;

      waited = 0;
      while (exp_q.size() != 0 && waited <= DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeouts++;
         $display("Writebacks missing: %0d expected writebacks never appeared",
                  exp_q.size());
      end
      // A few more cycles to catch stray writebacks
      repeat (4) @(posedge clk);
      foreach (same_tags[i]) check_cycle_order(same_tags[i], 1'b1);
      foreach (later_tags[i]) check_cycle_order(later_tags[i], 1'b0);

      assert_fails = c16_core_inst.c16_asserts_inst.fail_count;
      $display("Checked %0d instructions: %0d errors, %0d timeouts, %0d assertion failures",
               n_inst, errors, timeouts, assert_fails);
      if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* verilog/c16_core.sv */
////////////////////////////////////////////////////////////
// Dual-issue c16 core top; instances and wiring only
// Writebacks appear one cycle after issue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module c16_core
   import c16_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  fetch_word_t fetch_word,
   input  logic        fetch_valid,
   output logic        fetch_ready,
   output writeback_t  wb_first,
   output writeback_t  wb_second
);

   queue_count_t    avail;
   queue_count_t    consume;
   word_t           inst_first;
   word_t           inst_second;
   reg_addr_t [3:0] rd_addr;
   word_t     [3:0] rd_value;
   issue_slot_t     slot_first;
   issue_slot_t     slot_second;
   slot_srcs_t      srcs_first;
   slot_srcs_t      srcs_second;
   issue_slot_t     issue_first;
   issue_slot_t     issue_second;

   ////////////////////////////////////////////////////////////
   // Front end
   ////////////////////////////////////////////////////////////
   instr_queue instr_queue_inst (
      .clk(clk), .reset(reset),
      .fetch_word(fetch_word), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
      .consume(consume), .avail(avail),
      .inst_first(inst_first), .inst_second(inst_second)
   );

   slot_decode decode_first (
      .inst(inst_first), .rd_addr0(rd_addr[0]), .rd_addr1(rd_addr[1]),
      .rd_value0(rd_value[0]), .rd_value1(rd_value[1]),
      .slot(slot_first), .srcs(srcs_first)
   );

   slot_decode decode_second (
      .inst(inst_second), .rd_addr0(rd_addr[2]), .rd_addr1(rd_addr[3]),
      .rd_value0(rd_value[2]), .rd_value1(rd_value[3]),
      .slot(slot_second), .srcs(srcs_second)
   );

   issue_ctrl issue_ctrl_inst (
      .clk(clk), .reset(reset), .avail(avail),
      .slot_first(slot_first), .slot_second(slot_second),
      .srcs_first(srcs_first), .srcs_second(srcs_second),
      .consume(consume), .issue_first(issue_first), .issue_second(issue_second)
   );

   ////////////////////////////////////////////////////////////
   // Register file and execute
   ////////////////////////////////////////////////////////////
   reg_file reg_file_inst (
      .clk(clk), .reset(reset), .rd_addr(rd_addr), .rd_value(rd_value),
      .wb_first(wb_first), .wb_second(wb_second)
   );

   exec_lane exec_first (.slot(issue_first), .wb(wb_first));
   exec_lane exec_second (.slot(issue_second), .wb(wb_second));

endmodule

/* verilog/c16_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, opcodes and bundles of the c16 core
// Instruction fields follow one fixed layout, see below
////////////////////////////////////////////////////////////

package c16_pkg;

   // Data and instruction width
   localparam int WORD_W = 16;
   localparam int IMM_W = 5;

   typedef logic [WORD_W-1:0] word_t;

   // Two instructions per fetch, low half is earlier
   typedef logic [2*WORD_W-1:0] fetch_word_t;

   localparam int NUM_REGS = 8;

   typedef logic [2:0] reg_addr_t;

   // Writes dropped, reads as zero
   localparam reg_addr_t NO_WRITE_REG = 3'd7;

   ////////////////////////////////////////////////////////////
   // Opcodes
   // Fields: opcode [15:11], rd [10:8], rs1 [7:5],
   // rs2 [2:0], signed imm5 [4:0]
   ////////////////////////////////////////////////////////////
   typedef logic [4:0] opcode_t;

   localparam opcode_t OPC_ADD_IMM = 5'd0;
   localparam opcode_t OPC_ADD_REG = 5'd1;
   localparam opcode_t OPC_SUB_IMM = 5'd2;
   localparam opcode_t OPC_SUB_REG = 5'd3;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_NOP
   } alu_op_e;

   // Instruction queue
   localparam int QUEUE_DEPTH = 4;

   typedef logic [2:0] queue_count_t;

   ////////////////////////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      alu_op_e   op;
      reg_addr_t dest;
      word_t     arg0;
      word_t     arg1;
   } issue_slot_t;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      writes;
      logic      uses_rs2;
   } slot_srcs_t;

   typedef struct packed {
      logic      en;
      reg_addr_t addr;
      word_t     value;
   } writeback_t;

endpackage

/* verilog/exec_lane.sv */
////////////////////////////////////////////////////////////
// One execute lane, combinational, 16-bit wrapping math
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_lane
   import c16_pkg::*;
(
   input  issue_slot_t slot,
   output writeback_t  wb
);

   always_comb begin
      wb.addr = slot.dest;
      case (slot.op)
         ALU_ADD: begin
            wb.en = 1'b1;
            wb.value = slot.arg0 + slot.arg1;
         end
         ALU_SUB: begin
            wb.en = 1'b1;
            wb.value = slot.arg0 - slot.arg1;
         end
         default: begin
            wb.en = 1'b0;
            wb.value = '0;
         end
      endcase
   end

endmodule

/* verilog/instr_queue.sv */
////////////////////////////////////////////////////////////
// Holds up to four instructions, oldest at entry 0
// Caller must never consume more than avail
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_queue
   import c16_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  fetch_word_t  fetch_word,
   input  logic         fetch_valid,
   output logic         fetch_ready,
   input  queue_count_t consume,
   output queue_count_t avail,
   output word_t        inst_first,
   output word_t        inst_second
);

   word_t        entries [QUEUE_DEPTH];
   word_t        next_entries [QUEUE_DEPTH];
   queue_count_t count;
   queue_count_t total;
   queue_count_t src;
   logic         xfer;
   word_t        fetch_lo;
   word_t        fetch_hi;

   assign fetch_lo = fetch_word[WORD_W-1:0];
   assign fetch_hi = fetch_word[2*WORD_W-1:WORD_W];

   // Room for a full word only
   assign fetch_ready = (count <= 3'd2);
   assign xfer = fetch_valid && fetch_ready;

   // Stored plus incoming, decode sees at most two
   assign total = count + (xfer ? 3'd2 : 3'd0);
   assign avail = (total >= 3'd2) ? 3'd2 : total;

   // Oldest two, falling through to the incoming word
   always_comb begin
      inst_first = (count != 3'd0) ? entries[0] : fetch_lo;
      if (count >= 3'd2) begin
         inst_second = entries[1];
      end else if (count == 3'd1) begin
         inst_second = fetch_lo;
      end else begin
         inst_second = fetch_hi;
      end
   end

   // Shift out consumed entries and append the new word behind the rest
   always_comb begin
      src = '0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         src = queue_count_t'(i) + consume;
         if (src < count) begin
            next_entries[i] = entries[src[1:0]];
         end else if (src == count) begin
            next_entries[i] = fetch_lo;
         end else begin
            next_entries[i] = fetch_hi;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         count <= total - consume;
      end
   end

   always_ff @(posedge clk) begin
      entries <= next_entries;
   end

endmodule

/* verilog/issue_ctrl.sv */
////////////////////////////////////////////////////////////
// Pairs the two decoded slots and registers what issues
// A dependent second slot waits and moves to lane first
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module issue_ctrl
   import c16_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  queue_count_t avail,
   input  issue_slot_t  slot_first,
   input  issue_slot_t  slot_second,
   input  slot_srcs_t   srcs_first,
   input  slot_srcs_t   srcs_second,
   output queue_count_t consume,
   output issue_slot_t  issue_first,
   output issue_slot_t  issue_second
);

   logic        hit_rs1;
   logic        hit_rs2;
   logic        hazard;
   issue_slot_t next_first;
   issue_slot_t next_second;

   ////////////////////////////////////////////////////////////
   // Dependency check
   ////////////////////////////////////////////////////////////

   // Second reads what first is about to write
   assign hit_rs1 = (slot_first.dest == srcs_second.rs1);
   assign hit_rs2 = srcs_second.uses_rs2 && (slot_first.dest == srcs_second.rs2);
   assign hazard = srcs_first.writes && (hit_rs1 || hit_rs2);

   always_comb begin
      if (avail == 3'd0) begin
         consume = 3'd0;
      end else if (avail == 3'd1 || hazard) begin
         consume = 3'd1;
      end else begin
         consume = 3'd2;
      end
   end

   ////////////////////////////////////////////////////////////
   // Issue registers
   ////////////////////////////////////////////////////////////

   // Lanes that do not issue carry a bubble
   always_comb begin
      next_first = slot_first;
      next_second = slot_second;
      if (consume == 3'd0) begin
         next_first.op = ALU_NOP;
      end
      if (consume != 3'd2) begin
         next_second.op = ALU_NOP;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_first.op <= ALU_NOP;
         issue_second.op <= ALU_NOP;
      end else begin
         issue_first <= next_first;
         issue_second <= next_second;
      end
   end

endmodule

/* verilog/reg_file.sv */
////////////////////////////////////////////////////////////
// Eight registers, four reads, two writes
// Register 7 is never written; lane second wins on a tie
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file
   import c16_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   // Ports 0..3: first0, first1, second0, second1
   input  reg_addr_t [3:0]       rd_addr,
   output word_t     [3:0]       rd_value,
   input  writeback_t            wb_first,
   input  writeback_t            wb_second
);

   word_t regs [NUM_REGS];
   logic  wr_first;
   logic  wr_second;

   assign wr_first = wb_first.en && (wb_first.addr != NO_WRITE_REG);
   assign wr_second = wb_second.en && (wb_second.addr != NO_WRITE_REG);

   ////////////////////////////////////////////////////////////
   // Reads with same-cycle forwarding
   ////////////////////////////////////////////////////////////
   always_comb begin
      for (int p = 0; p < 4; p++) begin
         rd_value[p] = regs[rd_addr[p]];
         if (wr_first && wb_first.addr == rd_addr[p]) begin
            rd_value[p] = wb_first.value;
         end
         // Later lane overrides
         if (wr_second && wb_second.addr == rd_addr[p]) begin
            rd_value[p] = wb_second.value;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Writes
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] <= '0;
         end
      end else begin
         if (wr_first) begin
            regs[wb_first.addr] <= wb_first.value;
         end
         // Last assignment wins when both target one register
         if (wr_second) begin
            regs[wb_second.addr] <= wb_second.value;
         end
      end
   end

endmodule

/* verilog/slot_decode.sv */
////////////////////////////////////////////////////////////
// One decode lane, purely combinational
// Unknown opcodes decode to a NOP that writes nothing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module slot_decode
   import c16_pkg::*;
(
   input  word_t       inst,
   output reg_addr_t   rd_addr0,
   output reg_addr_t   rd_addr1,
   input  word_t       rd_value0,
   input  word_t       rd_value1,
   output issue_slot_t slot,
   output slot_srcs_t  srcs
);

   opcode_t opcode;
   word_t   imm;

   assign opcode = inst[15:11];
   assign rd_addr0 = inst[7:5];
   assign rd_addr1 = inst[2:0];

   // Sign extended imm5
   assign imm = {{(WORD_W-IMM_W){inst[IMM_W-1]}}, inst[IMM_W-1:0]};

   always_comb begin
      slot.dest = inst[10:8];
      slot.arg0 = rd_value0;
      srcs.rs1 = rd_addr0;
      srcs.rs2 = rd_addr1;
      srcs.writes = 1'b1;
      srcs.uses_rs2 = opcode[0];
      slot.arg1 = opcode[0] ? rd_value1 : imm;
      case (opcode)
         OPC_ADD_IMM, OPC_ADD_REG: slot.op = ALU_ADD;
         OPC_SUB_IMM, OPC_SUB_REG: slot.op = ALU_SUB;
         default: begin
            slot.op = ALU_NOP;
            srcs.writes = 1'b0;
            srcs.uses_rs2 = 1'b0;
         end
      endcase
   end

endmodule

/* vlog.f */
verilog/c16_pkg.sv
verilog/instr_queue.sv
verilog/slot_decode.sv
verilog/issue_ctrl.sv
verilog/reg_file.sv
verilog/exec_lane.sv
verilog/c16_core.sv
verif/c16_asserts.sv
verif/c16_tb.sv
